/* hw/macPkg.sv */
//////////////////////////////
// MAC shared definitions
// Address fields, request words and state encodings
//////////////////////////////
package macPkg;

  // Request address and its SDRAM fields
  localparam int addrW   = 32;
  localparam int rowLsb  = 19;
  localparam int rowW    = 11;   // Bits 29:19
  localparam int bankLsb = 8;
  localparam int bankW   = 2;    // Bits 9:8
  localparam int colW    = 8;    // Bits 7:0
  localparam int numBanks = 1 << bankW;

  // Request side-band widths
  localparam int tagW = 4;
  localparam int idW  = 3;
  localparam int lenW = 2;
  localparam int qosW = 4;

  localparam int beatsW     = 4;   // Saturates at 15
  localparam int queueAddrW = 5;   // 32 entries per queue

  // Request as seen on either channel
  typedef struct packed {
    logic [addrW-1:0] addr;
    logic [tagW-1:0]  tag;
    logic [idW-1:0]   id;
    logic [lenW-1:0]  len;
    logic [qosW-1:0]  qos;
  } reqInfoT;

  // One word in a request queue
  typedef struct packed {
    reqInfoT           info;
    logic              isLoad;
    logic [beatsW-1:0] beats;
  } queueEntryT;

  typedef struct packed {
    logic              isLoad;
    logic [bankW-1:0]  bank;
    logic [rowW-1:0]   row;
    logic [colW-1:0]   col;
    logic [tagW-1:0]   tag;
    logic [idW-1:0]    id;
    logic [lenW-1:0]   len;
    logic [qosW-1:0]   qos;
    logic [beatsW-1:0] beats;
    logic              rowHit;
  } schedReqT;

  // Write channel burst FSM
  typedef enum logic [1:0] {
    idle,
    fetchReq,
    fetchData,
    lastData
  } intakeStateT;

  // Last queue served
  typedef enum logic [1:0] {
    grantNone,
    grantWrite,
    grantRead
  } grantT;

endpackage

/* hw/syncFifo.sv */
//////////////////////////////
// Single-clock FIFO with
// registered read data
//////////////////////////////
module syncFifo #(
  parameter int dataW = 8,
  parameter int addrW = 4
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             push,
  input  logic [dataW-1:0] pushData,
  input  logic             pop,
  output logic [dataW-1:0] outData,
  output logic             outValid,
  output logic             full,
  output logic             empty
);

  logic [dataW-1:0] mem [1 << addrW];
  logic [addrW-1:0] wrPtr;
  logic [addrW-1:0] rdPtr;
  logic [addrW:0]   count;
  logic             doPush;
  logic             doPop;

  // Full is raised one entry early so a push already in flight still fits
  assign full   = (count >= ((1 << addrW) - 1));
  assign empty  = (count == '0);
  assign doPush = push && (count < (1 << addrW));
  assign doPop  = pop && !empty;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      outValid <= 1'b0;
    end else begin
      outValid <= doPop;
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read word
  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= pushData;
    if (doPop) outData <= mem[rdPtr];
  end

endmodule

/* hw/requestIntake.sv */
//////////////////////////////
// Request intake: write burst FSM
// and read enqueue into the queues
//////////////////////////////
module requestIntake import macPkg::*; (
  input  logic       clk,
  input  logic       resetn,
  // Read channel
  input  logic       rdValid,
  input  reqInfoT    rdReq,
  output logic       rdReady,
  // Write channel
  input  logic       wrValid,
  input  reqInfoT    wrReq,
  input  logic       wrEoD,
  output logic       wrReady,
  // Queue side
  input  logic       rdFull,
  input  logic       wrFull,
  output logic       rdPush,
  output queueEntryT rdPushData,
  output logic       wrPush,
  output queueEntryT wrPushData
);

  intakeStateT       state;
  intakeStateT       nextState;
  reqInfoT           wrInfo;
  logic [beatsW-1:0] beatCount;
  logic              wrAccept;
  logic              rdAccept;
  logic              beatCycle;

  assign rdReady  = !rdFull;
  assign wrReady  = !wrFull && (state == idle);
  assign rdAccept = rdValid && rdReady;
  assign wrAccept = wrValid && wrReady;

  // Data beats arrive in these two states
  assign beatCycle = (state == fetchReq) || (state == fetchData);

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (wrAccept) nextState = fetchReq;
      end
      fetchReq, fetchData: begin
        nextState = wrEoD ? lastData : fetchData;
      end
      lastData: begin
        nextState = idle;
      end
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state     <= idle;
      beatCount <= '0;
    end else begin
      state <= nextState;
      if (wrAccept) begin
        beatCount <= '0;
      end else if (beatCycle && (beatCount != '1)) begin
        beatCount <= beatCount + 1'b1;   // Saturating
      end
    end
  end

  // Write request held for the burst
  always_ff @(posedge clk) begin
    if (wrAccept) wrInfo <= wrReq;
  end

  // One push per burst, carrying the beat count
  assign wrPush = (state == lastData);

  always_comb begin
    wrPushData.info   = wrInfo;
    wrPushData.isLoad = 1'b0;
    wrPushData.beats  = beatCount;
  end

  // Reads go straight in, one cycle after acceptance
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      rdPush <= 1'b0;
    end else begin
      rdPush <= rdAccept;
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rdPushData.info   <= rdReq;
      rdPushData.isLoad <= 1'b1;
      rdPushData.beats  <= '0;
    end
  end

endmodule

/* hw/queueArbiter.sv */
//////////////////////////////
// Round-robin pick between
// write and read queues
//////////////////////////////
module queueArbiter import macPkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic wrEmpty,
  input  logic rdEmpty,
  output logic wrPop,
  output logic rdPop
);

  grantT lastGrant;
  grantT grant;

  always_comb begin
    grant = grantNone;
    if (!wrEmpty && !rdEmpty) begin
      // Alternate, writes first after idle
      grant = (lastGrant == grantWrite) ? grantRead : grantWrite;
    end else if (!wrEmpty) begin
      grant = grantWrite;
    end else if (!rdEmpty) begin
      grant = grantRead;
    end
  end

  assign wrPop = (grant == grantWrite);
  assign rdPop = (grant == grantRead);

  // Falls back to grantNone when both queues drain
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      lastGrant <= grantNone;
    end else begin
      lastGrant <= grant;
    end
  end

endmodule

/* hw/bankScheduler.sv */
//////////////////////////////
// Bank scheduler: address decode,
// open-row tracking, output stage
//////////////////////////////
module bankScheduler import macPkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  logic       wrOutValid,
  input  queueEntryT wrOutData,
  input  logic       rdOutValid,
  input  queueEntryT rdOutData,
  output logic       schedValid,
  output schedReqT   schedReq
);

  queueEntryT       entry;
  logic             entryValid;
  logic [bankW-1:0] bank;
  logic [rowW-1:0]  row;
  logic [colW-1:0]  col;
  logic             rowHit;

  logic [numBanks-1:0] bankOpen;
  logic [rowW-1:0]     openRow [numBanks];

  // Only one queue returns a word in any cycle
  assign entryValid = wrOutValid || rdOutValid;
  assign entry      = wrOutValid ? wrOutData : rdOutData;

  assign bank = entry.info.addr[bankLsb +: bankW];
  assign row  = entry.info.addr[rowLsb +: rowW];
  assign col  = entry.info.addr[colW-1:0];

  assign rowHit = bankOpen[bank] && (openRow[bank] == row);

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      schedValid <= 1'b0;
      bankOpen   <= '0;
    end else begin
      schedValid <= entryValid;
      if (entryValid) bankOpen[bank] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (entryValid) begin
      openRow[bank]   <= row;   // Row left open in this bank
      schedReq.isLoad <= entry.isLoad;
      schedReq.bank   <= bank;
      schedReq.row    <= row;
      schedReq.col    <= col;
      schedReq.tag    <= entry.info.tag;
      schedReq.id     <= entry.info.id;
      schedReq.len    <= entry.info.len;
      schedReq.qos    <= entry.info.qos;
      schedReq.beats  <= entry.beats;
      schedReq.rowHit <= rowHit;
    end
  end

endmodule

/* hw/memAccessController.sv */
//////////////////////////////
// Memory access controller
// request front end, top level
//////////////////////////////
module memAccessController import macPkg::*; (
  input  logic     clk,
  input  logic     resetn,
  // Read channel
  input  logic     rdValid,
  input  reqInfoT  rdReq,
  output logic     rdReady,
  // Write channel
  input  logic     wrValid,
  input  reqInfoT  wrReq,
  input  logic     wrEoD,
  output logic     wrReady,
  // Scheduled request stream
  output logic     schedValid,
  output schedReqT schedReq
);

  logic       rdPush;
  logic       wrPush;
  queueEntryT rdPushData;
  queueEntryT wrPushData;
  logic       rdFull;
  logic       wrFull;
  logic       rdEmpty;
  logic       wrEmpty;
  logic       rdPop;
  logic       wrPop;
  queueEntryT rdOutData;
  queueEntryT wrOutData;
  logic       rdOutValid;
  logic       wrOutValid;

  requestIntake intake0 (
    .clk        (clk),
    .resetn     (resetn),
    .rdValid    (rdValid),
    .rdReq      (rdReq),
    .rdReady    (rdReady),
    .wrValid    (wrValid),
    .wrReq      (wrReq),
    .wrEoD      (wrEoD),
    .wrReady    (wrReady),
    .rdFull     (rdFull),
    .wrFull     (wrFull),
    .rdPush     (rdPush),
    .rdPushData (rdPushData),
    .wrPush     (wrPush),
    .wrPushData (wrPushData)
  );

  syncFifo #(.dataW($bits(queueEntryT)), .addrW(queueAddrW)) wrQueue (
    .clk      (clk),
    .resetn   (resetn),
    .push     (wrPush),
    .pushData (wrPushData),
    .pop      (wrPop),
    .outData  (wrOutData),
    .outValid (wrOutValid),
    .full     (wrFull),
    .empty    (wrEmpty)
  );

  syncFifo #(.dataW($bits(queueEntryT)), .addrW(queueAddrW)) rdQueue (
    .clk      (clk),
    .resetn   (resetn),
    .push     (rdPush),
    .pushData (rdPushData),
    .pop      (rdPop),
    .outData  (rdOutData),
    .outValid (rdOutValid),
    .full     (rdFull),
    .empty    (rdEmpty)
  );

  queueArbiter arbiter0 (
    .clk     (clk),
    .resetn  (resetn),
    .wrEmpty (wrEmpty),
    .rdEmpty (rdEmpty),
    .wrPop   (wrPop),
    .rdPop   (rdPop)
  );

  bankScheduler scheduler0 (
    .clk        (clk),
    .resetn     (resetn),
    .wrOutValid (wrOutValid),
    .wrOutData  (wrOutData),
    .rdOutValid (rdOutValid),
    .rdOutData  (rdOutData),
    .schedValid (schedValid),
    .schedReq   (schedReq)
  );

endmodule

/* verification/macTb.sv */
//////////////////////////////
// Testbench for the memory access
// controller request front end
//////////////////////////////
module macTb import macPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int readsA   = 24;
  localparam int writesB  = 10;
  localparam int readsC   = 40;
  localparam int writesC  = 14;
  localparam int maxBurst = 20;
  localparam int stimCycles = readsA + writesB * (maxBurst + 3) + readsC * 2
                              + writesC * (maxBurst + 3) + 50;
  localparam int timeoutCycles = 4 * stimCycles + 200;

  // Expected queue word, with the edge at which it lands in its queue
  typedef struct {
    reqInfoT    info;
    logic       isLoad;
    logic [3:0] beats;
    int         qEdge;
  } expEntryT;

  logic     clk;
  logic     resetn;
  logic     rdValid;
  reqInfoT  rdReq;
  logic     rdReady;
  logic     wrValid;
  reqInfoT  wrReq;
  logic     wrEoD;
  logic     wrReady;
  logic     schedValid;
  schedReqT schedReq;

  expEntryT    rdModel[$];
  expEntryT    wrModel[$];
  logic [3:0]  bankSeen;
  logic [10:0] bankRow [4];

  int   cycleNo = 0;
  int   errorCount = 0;
  int   checkCount = 0;
  int   readsOut = 0;
  int   writesOut = 0;
  logic haveLast = 1'b0;
  logic lastLoad = 1'b0;
  int   lastOutCycle = 0;

  memAccessController dut0 (
    .clk(clk), .resetn(resetn),
    .rdValid(rdValid), .rdReq(rdReq), .rdReady(rdReady),
    .wrValid(wrValid), .wrReq(wrReq), .wrEoD(wrEoD), .wrReady(wrReady),
    .schedValid(schedValid), .schedReq(schedReq)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  always @(posedge clk) cycleNo <= cycleNo + 1;

  task automatic checkEq(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checkCount++;
    assert (actual === expected)
      else begin
        errorCount++;
        $display("ERROR at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      end
  endtask

  task automatic checkTrue(input string what, input logic cond);
    checkCount++;
    assert (cond)
      else begin
        errorCount++;
        $display("At %0d ns: %s", $time, what);
      end
  endtask

  task automatic printCounts();
    $display("Checks: %0d, errors: %0d, reads out: %0d, writes out: %0d",
             checkCount, errorCount, readsOut, writesOut);
  endtask

  // Rows come from a small set so banks see repeats
  function automatic reqInfoT randomReq();
    reqInfoT r;
    r.addr = $urandom;
    case ($urandom % 3)
      0:       r.addr[29:19] = 11'h012;
      1:       r.addr[29:19] = 11'h3a5;
      default: r.addr[29:19] = 11'h7ff;
    endcase
    r.tag = 4'($urandom);
    r.id  = 3'($urandom);
    r.len = 2'($urandom);
    r.qos = 4'($urandom);
    return r;
  endfunction

  // True when the output carries the identity fields of this request
  function automatic logic matchesOutput(input expEntryT e);
    return (schedReq.bank == e.info.addr[9:8]) && (schedReq.col == e.info.addr[7:0])
           && (schedReq.tag == e.info.tag) && (schedReq.id == e.info.id);
  endfunction

  // Called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic sendRead(input reqInfoT r);
    expEntryT e;
    rdValid = 1'b1;
    rdReq   = r;
    while (!rdReady) begin
      @(posedge clk);
      #1;
    end
    e.info   = r;
    e.isLoad = 1'b1;
    e.beats  = 4'd0;
    e.qEdge  = cycleNo + 2;   // Registered push one cycle later
    rdModel.push_back(e);
    @(posedge clk);
    #1;
  endtask

  task automatic sendWrite(input reqInfoT w, input int n);
    expEntryT e;
    while (!wrReady) begin
      @(posedge clk);
      #1;
    end
    wrValid  = 1'b1;
    wrReq    = w;
    e.info   = w;
    e.isLoad = 1'b0;
    e.beats  = (n > 15) ? 4'd15 : 4'(n);
    e.qEdge  = cycleNo + n + 2;
    wrModel.push_back(e);
    @(posedge clk);
    #1;
    wrValid = 1'b0;
    for (int i = 1; i <= n; i++) begin
      wrEoD = (i == n);
      checkEq("wrReady", 32'd0, wrReady);
      @(posedge clk);
      #1;
    end
    wrEoD = 1'b0;
    checkEq("wrReady", 32'd0, wrReady);   // lastData cycle
  endtask

  task automatic readStream(input int count);
    for (int i = 0; i < count; i++) begin
      sendRead(randomReq());
      if ($urandom % 4 == 0) begin
        rdValid = 1'b0;
        @(posedge clk);
        #1;
      end
    end
    rdValid = 1'b0;
  endtask

  task automatic writeStream(input int count);
    for (int i = 0; i < count; i++) begin
      sendWrite(randomReq(), 1 + ($urandom % maxBurst));
    end
  endtask

  task automatic checkOutput();
    expEntryT    e;
    expEntryT    other;
    logic [1:0]  bank;
    logic [10:0] row;
    logic        expHit;
    logic        rdHead;
    logic        wrHead;
    logic        fromRead;
    rdHead = 1'b0;
    wrHead = 1'b0;
    if (rdModel.size() != 0) rdHead = matchesOutput(rdModel[0]);
    if (wrModel.size() != 0) wrHead = matchesOutput(wrModel[0]);
    checkTrue("output matches neither oldest pending read nor oldest pending write",
              rdHead || wrHead);
    if (!rdHead && !wrHead) return;
    fromRead = rdHead && (!wrHead || schedReq.isLoad);   // Tie only on equal fields
    if (fromRead) begin
      e = rdModel.pop_front();
      readsOut++;
    end else begin
      e = wrModel.pop_front();
      writesOut++;
    end
    bank   = e.info.addr[9:8];
    row    = e.info.addr[29:19];
    expHit = bankSeen[bank] && (bankRow[bank] == row);
    bankSeen[bank] = 1'b1;
    bankRow[bank]  = row;
    checkEq("schedReq.isLoad", e.isLoad, schedReq.isLoad);
    checkEq("schedReq.row", row, schedReq.row);
    checkEq("schedReq.len", e.info.len, schedReq.len);
    checkEq("schedReq.qos", e.info.qos, schedReq.qos);
    checkEq("schedReq.beats", e.beats, schedReq.beats);
    checkEq("schedReq.rowHit", expHit, schedReq.rowHit);
    // Other channel waiting since the previous pop decision must win now
    if (haveLast && (lastLoad == fromRead)) begin
      if (fromRead && wrModel.size() != 0) begin
        other = wrModel[0];
        checkTrue("two reads in a row while a queued write waited",
                  !(other.qEdge + 2 <= lastOutCycle));
      end else if (!fromRead && rdModel.size() != 0) begin
        other = rdModel[0];
        checkTrue("two writes in a row while a queued read waited",
                  !(other.qEdge + 2 <= lastOutCycle));
      end
    end
    haveLast     = 1'b1;
    lastLoad     = fromRead;
    lastOutCycle = cycleNo;
  endtask

  always @(negedge clk) begin
    if (resetn && schedValid) checkOutput();
  end

  initial begin
    while (cycleNo < timeoutCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
    errorCount++;
    printCounts();
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h6573_7f59));
    resetn   = 1'b0;
    rdValid  = 1'b0;
    rdReq    = '0;
    wrValid  = 1'b0;
    wrReq    = '0;
    wrEoD    = 1'b0;
    bankSeen = '0;
    repeat (3) @(posedge clk);
    #1 resetn = 1'b1;
    repeat (6) begin
      @(posedge clk);
      #1;
      checkEq("schedValid", 32'd0, schedValid);
      checkEq("rdReady", 32'd1, rdReady);
      checkEq("wrReady", 32'd1, wrReady);
    end
    readStream(readsA);
    // Fixed lengths cover single beat and saturation
    sendWrite(randomReq(), 1);
    sendWrite(randomReq(), 15);
    sendWrite(randomReq(), 16);
    sendWrite(randomReq(), maxBurst);
    writeStream(writesB - 4);
    fork
      readStream(readsC);
      writeStream(writesC);
    join
    while (rdModel.size() != 0 || wrModel.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (10) @(posedge clk);
    printCounts();
    if (errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
hw/macPkg.sv
hw/syncFifo.sv
hw/requestIntake.sv
hw/queueArbiter.sv
hw/bankScheduler.sv
hw/memAccessController.sv
verification/macTb.sv

/* Makefile */
# Verilator build and run of the request front end testbench

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module macTb \
		-f sources.f --Mdir obj_dir -o macSim
	./obj_dir/macSim | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
